/* core_pkg.sv */
package core_pkg;

    // ====================================================================
    // widths and sizes
    // ====================================================================
    typedef logic [31:0] xlen_t;
    typedef xlen_t       word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;

    localparam int imem_depth = 64;
    localparam int dmem_depth = 64;
    localparam int imem_aw    = $clog2(imem_depth);
    localparam int dmem_aw    = $clog2(dmem_depth);

    // a store to this address ends the program, it lies past the data memory
    localparam xlen_t done_addr = 32'h0000_0100;

    // ====================================================================
    // encodings
    // ====================================================================
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_srl
    } alu_op_e;

    typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_e;

    typedef enum logic {wb_alu, wb_mem} wb_sel_e;

    // ====================================================================
    // pipeline registers and ports
    // ====================================================================
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     imm;
        xlen_t     rs1_val;
        xlen_t     rs2_val;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      is_branch;
        logic      branch_ne;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        xlen_t     alu_result;
        xlen_t     store_data;
        reg_addr_t rd;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        xlen_t     wb_data;
        reg_addr_t rd;
        logic      reg_write;
    } mem_wb_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
    } retire_t;

    typedef struct packed {
        logic  we;
        xlen_t addr;
        xlen_t data;
    } store_t;

endpackage

/* fetch_stage.sv */
module fetch_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  logic              branch_taken,
    input  core_pkg::xlen_t   branch_target,
    output core_pkg::if_id_t  if_id
);
    import core_pkg::*;

    xlen_t pc;
    inst_t imem [imem_depth];

    // words past the end of the program read as zero and decode as bubbles
    initial begin
        for (int i = 0; i < imem_depth; i++) begin
            imem[i] = '0;
        end
        $readmemh("program.hex", imem);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;  // redirect wins over a stall
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id.pc   <= pc;
            if_id.inst <= imem[pc[imem_aw+1:2]];
        end
        if (!rst_n || flush) begin
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if_id.valid <= 1'b1;
        end
    end

endmodule

/* decode_stage.sv */
module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 flush,
    input  core_pkg::if_id_t     if_id,
    output core_pkg::reg_addr_t  rs1_addr,
    output core_pkg::reg_addr_t  rs2_addr,
    input  core_pkg::xlen_t      rs1_data,
    input  core_pkg::xlen_t      rs2_data,
    output core_pkg::id_ex_t     id_ex
);
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    logic       legal;
    id_ex_t     id_next;

    assign opcode    = opcode_e'(if_id.inst[6:0]);
    assign funct3    = if_id.inst[14:12];
    assign funct7_b5 = if_id.inst[30];
    assign rs1_addr  = if_id.inst[19:15];
    assign rs2_addr  = if_id.inst[24:20];

    assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
    assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
    assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
                    if_id.inst[30:25], if_id.inst[11:8], 1'b0};

    always_comb begin
        id_next         = '0;
        id_next.pc      = if_id.pc;
        id_next.rs1_val = rs1_data;
        id_next.rs2_val = rs2_data;
        id_next.rs1     = rs1_addr;
        id_next.rs2     = rs2_addr;
        id_next.rd      = if_id.inst[11:7];
        id_next.alu_op  = alu_add;
        legal           = 1'b1;

        case (opcode)
            op_reg, op_imm: begin
                id_next.reg_write = 1'b1;
                id_next.use_imm   = (opcode == op_imm);
                id_next.imm       = imm_i;  // shamt sits in the low five bits
                case (funct3)
                    3'b000: begin
                        // only the register form has sub
                        if (opcode == op_reg && funct7_b5) id_next.alu_op = alu_sub;
                        else id_next.alu_op = alu_add;
                    end
                    3'b001:  id_next.alu_op = alu_sll;
                    3'b010:  id_next.alu_op = alu_slt;
                    3'b100:  id_next.alu_op = alu_xor;
                    3'b101:  id_next.alu_op = alu_srl;
                    3'b110:  id_next.alu_op = alu_or;
                    3'b111:  id_next.alu_op = alu_and;
                    default: legal = 1'b0;  // sltu is not supported
                endcase
            end
            op_load: begin
                id_next.use_imm   = 1'b1;
                id_next.imm       = imm_i;
                id_next.mem_read  = 1'b1;
                id_next.reg_write = 1'b1;
            end
            op_store: begin
                id_next.use_imm   = 1'b1;
                id_next.imm       = imm_s;
                id_next.mem_write = 1'b1;
            end
            op_branch: begin
                id_next.imm       = imm_b;
                id_next.is_branch = 1'b1;
                id_next.branch_ne = funct3[0];
                legal             = (funct3[2:1] == 2'b00);  // beq and bne only
            end
            default: legal = 1'b0;
        endcase

        if (id_next.rd == '0) id_next.reg_write = 1'b0;

        id_next.valid = if_id.valid && legal;
        if (!id_next.valid) begin
            id_next.reg_write = 1'b0;
            id_next.mem_read  = 1'b0;
            id_next.mem_write = 1'b0;
            id_next.is_branch = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        id_ex <= id_next;
        // a stall or a flush turns this slot into a bubble
        if (!rst_n || stall || flush) begin
            id_ex.valid     <= 1'b0;
            id_ex.reg_write <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.is_branch <= 1'b0;
        end
    end

endmodule

/* regfile.sv */
module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::reg_addr_t  rs1_addr,
    input  core_pkg::reg_addr_t  rs2_addr,
    output core_pkg::xlen_t      rs1_data,
    output core_pkg::xlen_t      rs2_data,
    input  core_pkg::retire_t    wr
);
    import core_pkg::*;

    xlen_t     regs  [32];
    reg_addr_t raddr [2];
    xlen_t     rdata [2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;  // x0 never changes
        end
    end

    assign raddr[0] = rs1_addr;
    assign raddr[1] = rs2_addr;

    // the write-back value reaches decode in the same cycle it is written
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (wr.we && wr.rd != '0 && wr.rd == raddr[p]) rdata[p] = wr.data;
            else rdata[p] = regs[raddr[p]];
        end
    end

    assign rs1_data = rdata[0];
    assign rs2_data = rdata[1];

endmodule

/* execute_stage.sv */
module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::id_ex_t    id_ex,
    input  core_pkg::fwd_sel_e  fwd_a,
    input  core_pkg::fwd_sel_e  fwd_b,
    input  core_pkg::xlen_t     mem_fwd,
    input  core_pkg::xlen_t     wb_fwd,
    output logic                branch_taken,
    output core_pkg::xlen_t     branch_target,
    output core_pkg::ex_mem_t   ex_mem
);
    import core_pkg::*;

    xlen_t rs1_fwd;
    xlen_t rs2_fwd;
    xlen_t op_b;
    xlen_t alu_result;

    function automatic xlen_t fwd_mux(fwd_sel_e sel, xlen_t reg_val, xlen_t mem_val,
                                      xlen_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign rs1_fwd = fwd_mux(fwd_a, id_ex.rs1_val, mem_fwd, wb_fwd);
    assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_val, mem_fwd, wb_fwd);
    assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_fwd;

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_result = rs1_fwd + op_b;
            alu_sub: alu_result = rs1_fwd - op_b;
            alu_and: alu_result = rs1_fwd & op_b;
            alu_or:  alu_result = rs1_fwd | op_b;
            alu_xor: alu_result = rs1_fwd ^ op_b;
            alu_slt: alu_result = {31'b0, $signed(rs1_fwd) < $signed(op_b)};
            alu_sll: alu_result = rs1_fwd << op_b[4:0];
            alu_srl: alu_result = rs1_fwd >> op_b[4:0];
            default: alu_result = '0;
        endcase
    end

    // beq and bne differ only in the sense of the compare
    assign branch_taken  = id_ex.valid && id_ex.is_branch &&
                           ((rs1_fwd == rs2_fwd) ^ id_ex.branch_ne);
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= rs2_fwd;
        ex_mem.rd         <= id_ex.rd;
        if (!rst_n) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else begin
            ex_mem.valid     <= id_ex.valid && !id_ex.is_branch;  // branches end here
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.reg_write <= id_ex.reg_write;
        end
    end

endmodule

/* memory_stage.sv */
module memory_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::ex_mem_t  ex_mem,
    output core_pkg::mem_wb_t  mem_wb,
    output core_pkg::store_t   store
);
    import core_pkg::*;

    word_t                dmem [dmem_depth];
    logic [dmem_aw-1:0]   word_idx;
    logic                 in_range;
    word_t                load_data;
    wb_sel_e              wb_sel;

    assign word_idx = ex_mem.alu_result[dmem_aw+1:2];
    assign in_range = (ex_mem.alu_result[31:dmem_aw+2] == '0);  // the done store falls outside

    assign store.we   = ex_mem.valid && ex_mem.mem_write;
    assign store.addr = ex_mem.alu_result;
    assign store.data = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (store.we && in_range) dmem[word_idx] <= ex_mem.store_data;
    end

    assign load_data = dmem[word_idx];
    assign wb_sel    = ex_mem.mem_read ? wb_mem : wb_alu;

    always_ff @(posedge clk) begin
        mem_wb.wb_data <= (wb_sel == wb_mem) ? load_data : ex_mem.alu_result;
        mem_wb.rd      <= ex_mem.rd;
        if (!rst_n) begin
            mem_wb.valid     <= 1'b0;
            mem_wb.reg_write <= 1'b0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.valid && ex_mem.reg_write;
        end
    end

endmodule

/* hazard_unit.sv */
module hazard_unit (
    input  core_pkg::if_id_t    if_id,
    input  core_pkg::id_ex_t    id_ex,
    input  core_pkg::ex_mem_t   ex_mem,
    input  core_pkg::mem_wb_t   mem_wb,
    input  logic                branch_taken,
    output logic                stall,
    output logic                flush,
    output core_pkg::fwd_sel_e  fwd_a,
    output core_pkg::fwd_sel_e  fwd_b
);
    import core_pkg::*;

    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    opcode_e   dec_opcode;
    logic      dec_uses_rs2;
    logic      load_in_ex;

    // the younger stage holds the newer value, so memory beats write-back
    function automatic fwd_sel_e fwd_pick(reg_addr_t rs, ex_mem_t em, mem_wb_t mw);
        if (rs == '0) return fwd_none;
        if (em.valid && em.reg_write && em.rd == rs) return fwd_mem;
        if (mw.valid && mw.reg_write && mw.rd == rs) return fwd_wb;
        return fwd_none;
    endfunction

    assign fwd_a = fwd_pick(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = fwd_pick(id_ex.rs2, ex_mem, mem_wb);

    assign dec_rs1      = if_id.inst[19:15];
    assign dec_rs2      = if_id.inst[24:20];
    assign dec_opcode   = opcode_e'(if_id.inst[6:0]);
    assign dec_uses_rs2 = dec_opcode inside {op_reg, op_store, op_branch};

    // load data is only ready in write-back, one cycle after a plain result
    assign load_in_ex = id_ex.valid && id_ex.mem_read && id_ex.rd != '0;
    assign stall      = load_in_ex && if_id.valid &&
                        (id_ex.rd == dec_rs1 || (dec_uses_rs2 && id_ex.rd == dec_rs2));
    assign flush      = branch_taken;

endmodule

/* core.sv */
module core (
    input  logic               clk,
    input  logic               rst_n,
    output core_pkg::retire_t  retire,
    output core_pkg::store_t   store
);
    import core_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      stall;
    logic      flush;
    logic      branch_taken;
    xlen_t     branch_target;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    // the write-back port is also what the outside sees retire
    assign retire.we   = mem_wb.valid && mem_wb.reg_write;
    assign retire.rd   = mem_wb.rd;
    assign retire.data = mem_wb.wb_data;

    fetch_stage fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .branch_taken(branch_taken), .branch_target(branch_target), .if_id(if_id)
    );

    decode_stage decode (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .if_id(if_id),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .id_ex(id_ex)
    );

    regfile rf (
        .clk(clk), .rst_n(rst_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .wr(retire)
    );

    execute_stage execute (
        .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd(ex_mem.alu_result), .wb_fwd(mem_wb.wb_data),
        .branch_taken(branch_taken), .branch_target(branch_target), .ex_mem(ex_mem)
    );

    memory_stage memory (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .mem_wb(mem_wb), .store(store)
    );

    hazard_unit hazard (
        .if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .branch_taken(branch_taken), .stall(stall), .flush(flush),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

endmodule

/* core_asserts.sv */
module core_asserts (
    input logic              clk,
    input logic              rst_n,
    input core_pkg::retire_t retire,
    input core_pkg::store_t  store
);
    import core_pkg::*;

    // the first instruction reaches memory on the fourth edge after reset and write-back a
    // cycle later
    localparam logic [2:0] store_quiet  = 3'd3;
    localparam logic [2:0] retire_quiet = 3'd4;

    int         fail_count = 0;
    logic [2:0] since_reset;  // saturating count of edges since reset went away

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            since_reset <= '0;
        end else if (since_reset != 3'd7) begin
            since_reset <= since_reset + 3'd1;
        end
    end

    // ====================================================================
    // retire port
    // ====================================================================
    no_x0_retire: assert property (@(posedge clk) disable iff (!rst_n)
        retire.we |-> retire.rd != '0)
        else begin
            $error("retire wrote register x0");
            fail_count++;
        end

    retire_known: assert property (@(posedge clk) disable iff (!rst_n)
        retire.we |-> !$isunknown(retire))
        else begin
            $error("retire carries unknown bits while we is set");
            fail_count++;
        end

    retire_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        since_reset < retire_quiet |-> !retire.we)
        else begin
            $error("retire fired too soon after reset");
            fail_count++;
        end

    // ====================================================================
    // store port
    // ====================================================================
    store_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        since_reset < store_quiet |-> !store.we)
        else begin
            $error("store fired too soon after reset");
            fail_count++;
        end

    store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        store.we |-> store.addr[1:0] == 2'b00)
        else begin
            $error("store address is not word aligned");
            fail_count++;
        end

endmodule

bind core core_asserts asserts0 (
    .clk(clk), .rst_n(rst_n), .retire(retire), .store(store)
);

/* tb_core.sv */
module tb_core;
    import core_pkg::*;

    typedef enum logic [2:0] {k_reg, k_imm, k_load, k_store, k_done} kind_e;

    typedef struct packed {
        kind_e     kind;
        reg_addr_t rd;
        xlen_t     data;
    } retire_ev_t;

    typedef struct packed {
        kind_e kind;
        xlen_t addr;
        xlen_t data;
    } store_ev_t;

    // about five cycles per program word covers fill, stalls and flushes
    localparam int max_cycles = imem_depth * 5 + 80;

    logic       clk;
    logic       rst_n;
    retire_t    retire;
    store_t     store;
    inst_t      prog [imem_depth];
    retire_ev_t exp_retires [$];
    store_ev_t  exp_stores [$];
    int         expected_n [5];
    int         seen_n [5];
    int         err_n [5];
    string      test_name [5];
    int         other_errors;
    int         cycles = 0;
    logic       done_seen;

    core dut0 (.clk(clk), .rst_n(rst_n), .retire(retire), .store(store));

    always #5 clk = ~clk;

    // ====================================================================
    // reference model of the RV32I subset
    // ====================================================================
    function automatic xlen_t alu_ref(logic [2:0] f3, logic sub, xlen_t a, xlen_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        xlen_t     regs [32];
        xlen_t     dm [dmem_depth];
        xlen_t     pc;
        xlen_t     next_pc;
        inst_t     inst;
        xlen_t     a;
        xlen_t     b;
        xlen_t     addr;
        xlen_t     res;
        reg_addr_t rd;
        kind_e     kind;
        logic      has_result;
        logic      finished;
        int        steps;
        store_ev_t s;

        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmem_depth; i++) begin
            dm[i] = '0;
        end
        pc       = '0;
        finished = 1'b0;
        steps    = 0;
        while (!finished && steps < imem_depth * 4) begin
            inst       = prog[pc[imem_aw+1:2]];
            a          = regs[inst[19:15]];
            b          = regs[inst[24:20]];
            rd         = inst[11:7];
            next_pc    = pc + 32'd4;
            has_result = 1'b0;
            kind       = k_reg;
            case (opcode_e'(inst[6:0]))
                op_reg: begin
                    res        = alu_ref(inst[14:12], inst[30], a, b);
                    has_result = 1'b1;
                end
                op_imm: begin
                    res        = alu_ref(inst[14:12], 1'b0, a, {{20{inst[31]}}, inst[31:20]});
                    kind       = k_imm;
                    has_result = 1'b1;
                end
                op_load: begin
                    addr       = a + {{20{inst[31]}}, inst[31:20]};
                    res        = dm[addr[dmem_aw+1:2]];
                    kind       = k_load;
                    has_result = 1'b1;
                end
                op_store: begin
                    addr   = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    s.kind = (addr == done_addr) ? k_done : k_store;
                    s.addr = addr;
                    s.data = b;
                    exp_stores.push_back(s);
                    expected_n[s.kind]++;
                    if (addr == done_addr) finished = 1'b1;
                    else dm[addr[dmem_aw+1:2]] = b;
                end
                op_branch: begin
                    // funct3 bit 0 turns beq into bne
                    if ((a == b) != inst[12]) begin
                        next_pc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            if (has_result && rd != '0) begin
                regs[rd] = res;
                exp_retires.push_back('{kind: kind, rd: rd, data: res});
                expected_n[kind]++;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    // ====================================================================
    // checks against the expected sequences
    // ====================================================================
    task automatic note_event(kind_e kind);
        seen_n[kind]++;
        if (seen_n[kind] == expected_n[kind]) begin
            $display("test %s: %0d events, %0d errors", test_name[kind], seen_n[kind],
                     err_n[kind]);
        end
    endtask

    task automatic check_retire();
        retire_ev_t e;
        if (exp_retires.size() == 0) begin
            $display("retire of x%0d at time %0t was not expected by the model", retire.rd, $time);
            other_errors++;
            return;
        end
        e = exp_retires.pop_front();
        assert (retire.rd == e.rd) else begin
            $display("[ERROR] %0t retire.rd expected %0d got %0d", $time, e.rd, retire.rd);
            err_n[e.kind]++;
        end
        assert (retire.data == e.data) else begin
            $display("[ERROR] %0t retire.data expected 0x%08h got 0x%08h", $time, e.data,
                     retire.data);
            err_n[e.kind]++;
        end
        note_event(e.kind);
    endtask

    task automatic check_store();
        store_ev_t e;
        if (store.addr == done_addr) done_seen = 1'b1;
        if (exp_stores.size() == 0) begin
            $display("store to 0x%08h at time %0t was not expected by the model", store.addr,
                     $time);
            other_errors++;
            return;
        end
        e = exp_stores.pop_front();
        assert (store.addr == e.addr) else begin
            $display("[ERROR] %0t store.addr expected 0x%08h got 0x%08h", $time, e.addr,
                     store.addr);
            err_n[e.kind]++;
        end
        assert (store.data == e.data) else begin
            $display("[ERROR] %0t store.data expected 0x%08h got 0x%08h", $time, e.data,
                     store.data);
            err_n[e.kind]++;
        end
        note_event(e.kind);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // outputs settle after the rising edge, so they are looked at on the falling one
    always @(negedge clk) begin
        if (rst_n && retire.we) check_retire();
        if (rst_n && store.we) check_store();
    end

    // ====================================================================
    // reset, run and summary
    // ====================================================================
    initial begin
        int failures;
        int events;

        clk          = 1'b0;
        rst_n        = 1'b0;
        other_errors = 0;
        done_seen    = 1'b0;
        test_name    = '{"reg-reg alu", "immediate alu", "load", "store", "done store"};
        for (int k = 0; k < 5; k++) begin
            expected_n[k] = 0;
            seen_n[k]     = 0;
            err_n[k]      = 0;
        end
        for (int i = 0; i < imem_depth; i++) begin
            prog[i] = '0;
        end
        $readmemh("program.hex", prog);
        run_model();

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        while (!done_seen && cycles < max_cycles) begin
            @(negedge clk);
        end

        if (!done_seen) begin
            $display("timeout: no store to the done address within %0d cycles", max_cycles);
            other_errors++;
        end
        if (exp_retires.size() != 0) begin
            $display("%0d expected retires never appeared", exp_retires.size());
            other_errors++;
        end
        if (exp_stores.size() != 0) begin
            $display("%0d expected stores never appeared", exp_stores.size());
            other_errors++;
        end

        failures = other_errors + dut0.asserts0.fail_count;
        events   = 0;
        for (int k = 0; k < 5; k++) begin
            failures += err_n[k];
            events   += seen_n[k];
        end
        $display("summary: %0d events checked, %0d failures, %0d assertion failures, %0d cycles",
                 events, failures, dut0.asserts0.fail_count, cycles);
        if (failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* list.f */
core_pkg.sv
fetch_stage.sv
decode_stage.sv
regfile.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
core.sv
core_asserts.sv
tb_core.sv

/* run.sh */
#!/bin/sh
# builds the core testbench with Verilator, runs it and looks for the pass line in sim.log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_core -f list.f -o tb_core; then
    echo "verilator build failed"
    exit 1
fi

# bound assertions report through $error, so the run must survive more than one of them
if ! ./obj_dir/tb_core +verilator+error+limit+100 > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

/* program.hex */
// one RV32I instruction word per line, loaded from word address 0 upward
// the text after each word is its assembly and the value it leaves
00600093 // addi x1, x0, 6      x1 = 6
00B00113 // addi x2, x0, 11     x2 = 11
002081B3 // add  x3, x1, x2     x3 = 17, forwarded at distance 1 and 2
40118233 // sub  x4, x3, x1     x4 = 11
0021F2B3 // and  x5, x3, x2     x5 = 1
0021E333 // or   x6, x3, x2     x6 = 27
0021C3B3 // xor  x7, x3, x2     x7 = 26
0020A433 // slt  x8, x1, x2     x8 = 1
008094B3 // sll  x9, x1, x8     x9 = 12
0081D533 // srl  x10, x3, x8    x10 = 8
FFD00593 // addi x11, x0, -3    x11 = -3
0015A633 // slt  x12, x11, x1   x12 = 1, signed compare
00F37693 // andi x13, x6, 15    x13 = 11
0300E713 // ori  x14, x1, 0x30  x14 = 54
FFF14793 // xori x15, x2, -1    x15 = ~11
FFE5A813 // slti x16, x11, -2   x16 = 1
00409893 // slli x17, x1, 4     x17 = 96
01C5D913 // srli x18, x11, 28   x18 = 15
00302423 // sw   x3, 8(x0)      mem[8] = 17
00802983 // lw   x19, 8(x0)     x19 = 17
00198A33 // add  x20, x19, x1   load-use stall, x20 = 23
00700013 // addi x0, x0, 7      write to x0 never retires
00398663 // beq  x19, x3, +12   taken
00100A93 // addi x21, x0, 1     flushed
00200A93 // addi x21, x0, 2     flushed
00109463 // bne  x1, x1, +8     not taken
00209663 // bne  x1, x2, +12    taken
00100B13 // addi x22, x0, 1     flushed
00200B13 // addi x22, x0, 2     flushed
01402623 // sw   x20, 12(x0)    mem[12] = 23
00C02B83 // lw   x23, 12(x0)    x23 = 23
11702023 // sw   x23, 256(x0)   done store, load-use on the store data
